/* design/core_pkg.sv */
package core_pkg;

	typedef logic [31:0] word;
	typedef logic [29:0] ptr; // Word address.
	typedef logic [3:0]  reg_num;

	localparam reg_num R14 = 4'd14; // Link register.

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	typedef enum logic [3:0] {
		eq = 4'b0000,
		ne = 4'b0001,
		cs = 4'b0010,
		cc = 4'b0011,
		mi = 4'b0100,
		pl = 4'b0101,
		vs = 4'b0110,
		vc = 4'b0111,
		hi = 4'b1000,
		ls = 4'b1001,
		ge = 4'b1010,
		lt = 4'b1011,
		gt = 4'b1100,
		le = 4'b1101,
		al = 4'b1110,
		nv = 4'b1111
	} cond_code;

	typedef enum logic [3:0] {
		op_and = 4'b0000,
		op_eor = 4'b0001,
		op_sub = 4'b0010,
		op_rsb = 4'b0011,
		op_add = 4'b0100,
		op_adc = 4'b0101,
		op_sbc = 4'b0110,
		op_rsc = 4'b0111,
		op_tst = 4'b1000,
		op_teq = 4'b1001,
		op_cmp = 4'b1010,
		op_cmn = 4'b1011,
		op_orr = 4'b1100,
		op_mov = 4'b1101,
		op_bic = 4'b1110,
		op_mvn = 4'b1111
	} alu_op;

	// Second operand, either a rotated immediate or a shifted register.
	typedef struct packed {
		logic       is_imm;
		word        imm;          // Already rotated.
		reg_num     r;
		logic       shift_by_reg;
		reg_num     rs;
		logic [4:0] shift_imm;    // Zero with shr stands for 32.
		logic       shl;
		logic       shr;
		logic       ror;
		logic       sign_extend;
		logic       rrx;
	} snd_decode;

	typedef struct packed {
		alu_op  op;
		reg_num rn;
		reg_num rd;
		logic   uses_rn;
		logic   uses_carry_in;
	} data_decode;

endpackage

/* design/core_decode_if.sv */
interface core_decode_if import core_pkg::*; ();

	logic       execute;
	logic       undefined;
	logic       writeback;
	logic       update_flags;
	logic       branch;
	ptr         branch_offset;
	snd_decode  snd_ctrl;
	data_decode data_ctrl;

	modport decoder (
		output execute, undefined, writeback, update_flags, branch,
		output branch_offset, snd_ctrl, data_ctrl
	);

	modport stage (
		input execute, undefined, writeback, update_flags, branch,
		input branch_offset, snd_ctrl, data_ctrl
	);

endinterface

/* design/core_decode_conds.sv */
module core_decode_conds import core_pkg::*; (
	input  cond_code cond,
	input  psr_flags flags,

	output logic     execute,
	output logic     undefined
);

	always_comb begin
		undefined = 1'b0;

		unique case (cond)
			eq: execute = flags.z;
			ne: execute = !flags.z;
			cs: execute = flags.c;
			cc: execute = !flags.c;
			mi: execute = flags.n;
			pl: execute = !flags.n;
			vs: execute = flags.v;
			vc: execute = !flags.v;

			hi: execute = flags.c && !flags.z;
			ls: execute = !flags.c || flags.z;

			// Signed comparisons.
			ge: execute = flags.n == flags.v;
			lt: execute = flags.n != flags.v;
			gt: execute = !flags.z && (flags.n == flags.v);
			le: execute = flags.z || (flags.n != flags.v);

			al: execute = 1'b1;

			nv: begin
				execute = 1'b0;
				undefined = 1'b1; // Reserved encoding.
			end
		endcase
	end

endmodule

/* design/core_decode_snd.sv */
module core_decode_snd import core_pkg::*; (
	input  word       insn,
	input  logic      is_imm,
	input  logic      shift_by_reg_if_reg,

	output snd_decode decode,
	output logic      undefined
);

	logic [5:0]  rotate;
	logic [63:0] imm_pair;
	logic [63:0] imm_rotated;

	// Rotate right by doubling the immediate and shifting the pair.
	assign rotate = {1'b0, insn[11:8], 1'b0};
	assign imm_pair = {2{24'd0, insn[7:0]}};
	assign imm_rotated = imm_pair >> rotate;

	always_comb begin
		decode.is_imm = is_imm;
		decode.imm = imm_rotated[31:0];
		decode.r = insn[3:0];
		decode.rs = insn[11:8];
		decode.shift_imm = insn[11:7];
		decode.shift_by_reg = !is_imm && shift_by_reg_if_reg;

		decode.shl = 1'b0;
		decode.shr = 1'b0;
		decode.ror = 1'b0;
		decode.sign_extend = 1'b0;
		decode.rrx = 1'b0;

		if (!is_imm) begin
			unique case (insn[6:5])
				2'b00: decode.shl = 1'b1;
				2'b01: decode.shr = 1'b1; // By 0 means by 32.
				2'b10: begin
					decode.shr = 1'b1;
					decode.sign_extend = 1'b1;
				end
				2'b11: begin
					if (!shift_by_reg_if_reg && insn[11:7] == 5'd0)
						decode.rrx = 1'b1;
					else
						decode.ror = 1'b1;
				end
			endcase
		end
	end

	// Bit 7 set here belongs to the multiply and extra load/store space.
	assign undefined = !is_imm && shift_by_reg_if_reg && insn[7];

endmodule

/* design/core_decode_data.sv */
module core_decode_data import core_pkg::*; (
	input  word        insn,

	output data_decode decode,
	output logic       writeback,
	output logic       update_flags,
	output logic       snd_is_imm,
	output logic       snd_shift_by_reg_if_reg
);

	alu_op op;
	logic  s_bit;
	logic  is_test;

	assign op = alu_op'(insn[24:21]);
	assign s_bit = insn[20];

	always_comb begin
		unique case (op)
			op_tst, op_teq, op_cmp, op_cmn:
				is_test = 1'b1;
			default:
				is_test = 1'b0;
		endcase
	end

	always_comb begin
		decode.op = op;
		decode.rn = insn[19:16];
		decode.rd = insn[15:12];

		// mov and mvn only look at the second operand.
		decode.uses_rn = !(op == op_mov || op == op_mvn);
		decode.uses_carry_in = op == op_adc || op == op_sbc || op == op_rsc;
	end

	// Comparisons always set the flags and have no destination.
	assign writeback = !is_test;
	assign update_flags = is_test || s_bit;

	assign snd_is_imm = insn[25];
	assign snd_shift_by_reg_if_reg = insn[4];

endmodule

/* design/core_decode.sv */
module core_decode import core_pkg::*; (
	input  word                  insn,
	input  psr_flags             flags,

	core_decode_if.decoder       dec
);

	logic cond_undefined;

	core_decode_conds conds (
		.cond(cond_code'(insn[31:28])),
		.flags(flags),
		.execute(dec.execute),
		.undefined(cond_undefined)
	);

	data_decode data;
	logic       data_writeback;
	logic       data_update_flags;
	logic       data_is_imm;
	logic       data_shift_by_reg_if_reg;

	core_decode_data group_data (
		.insn(insn),
		.decode(data),
		.writeback(data_writeback),
		.update_flags(data_update_flags),
		.snd_is_imm(data_is_imm),
		.snd_shift_by_reg_if_reg(data_shift_by_reg_if_reg)
	);

	snd_decode snd;
	logic      snd_undefined;

	core_decode_snd snd_operand (
		.insn(insn),
		.is_imm(data_is_imm),
		.shift_by_reg_if_reg(data_shift_by_reg_if_reg),
		.decode(snd),
		.undefined(snd_undefined)
	);

	always_comb begin
		dec.undefined = cond_undefined;
		dec.writeback = 1'b0;
		dec.update_flags = 1'b0;
		dec.branch = 1'b0;
		dec.branch_offset = '0;
		dec.snd_ctrl = '0;
		dec.data_ctrl = '0;

		priority casez ({insn[27:20], insn[7:4]})
			12'b0000_00??_1001: ; // mul, mla
			12'b0000_1???_1001: ; // Long multiply.
			12'b0001_0?00_1001: ; // swp
			12'b000?_????_1??1: ; // Halfword and signed loads and stores.
			12'b0001_0?00_0000: ; // mrs
			12'b0001_0?10_0000: ; // Register form of msr.
			12'b0011_0?10_????: ; // Immediate form of msr.

			12'b00??_????_????: begin
				dec.snd_ctrl = snd;
				dec.data_ctrl = data;
				dec.writeback = data_writeback;
				dec.update_flags = data_update_flags;
				dec.undefined = cond_undefined | snd_undefined;
			end

			12'b011?_????_???1:
				dec.undefined = 1'b1; // Media space.

			12'b01??_????_????: ; // ldr, str
			12'b100?_????_????: ; // ldm, stm

			12'b101?_????_????: begin
				dec.branch = 1'b1;
				dec.branch_offset = {{6{insn[23]}}, insn[23:0]};
				if (insn[24]) begin
					dec.data_ctrl.rd = R14;
					dec.writeback = 1'b1;
				end
			end

			12'b110?_????_????: ; // Coprocessor transfers.
			12'b1110_????_????: ; // Coprocessor data and register moves.
			12'b1111_????_????: ; // swi
		endcase
	end

endmodule

/* design/core_decode_stage.sv */
module core_decode_stage import core_pkg::*; (
	input  logic       clk,
	input  logic       reset,

	input  logic       in_valid,
	input  word        insn,
	input  psr_flags   flags,

	output logic       out_valid,
	output logic       execute,
	output logic       undefined,
	output logic       writeback,
	output logic       update_flags,
	output logic       branch,
	output ptr         branch_offset,
	output snd_decode  snd_ctrl,
	output data_decode data_ctrl
);

	core_decode_if dec_bus ();

	core_decode decode (
		.insn(insn),
		.flags(flags),
		.dec(dec_bus.decoder)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			undefined <= 1'b0;
			writeback <= 1'b0;
			update_flags <= 1'b0;
			branch <= 1'b0;
		end else begin
			out_valid <= in_valid; // One cycle per strobe.
			if (in_valid) begin
				undefined <= dec_bus.undefined;
				writeback <= dec_bus.writeback;
				update_flags <= dec_bus.update_flags;
				branch <= dec_bus.branch;
			end
		end
	end

	always_ff @(posedge clk)
		if (in_valid) begin
			execute <= dec_bus.execute;
			branch_offset <= dec_bus.branch_offset;
			snd_ctrl <= dec_bus.snd_ctrl;
			data_ctrl <= dec_bus.data_ctrl;
		end

endmodule

/* tests/core_decode_tb.sv */
module core_decode_tb import core_pkg::*; ();

	localparam int clk_period = 40;
	localparam int test_cycles = 5 + 1 + 256 + 200 + 24 + 13 + 5;

	localparam int cls_other = 0;
	localparam int cls_alu = 1;
	localparam int cls_media = 2;
	localparam int cls_branch = 3;

	logic       clk;
	logic       reset;
	logic       in_valid;
	word        insn;
	psr_flags   flags;
	logic       out_valid;
	logic       execute;
	logic       undefined;
	logic       writeback;
	logic       update_flags;
	logic       branch;
	ptr         branch_offset;
	snd_decode  snd_ctrl;
	data_decode data_ctrl;
	int         errors;

	core_decode_stage i_dut (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.insn(insn),
		.flags(flags),
		.out_valid(out_valid),
		.execute(execute),
		.undefined(undefined),
		.writeback(writeback),
		.update_flags(update_flags),
		.branch(branch),
		.branch_offset(branch_offset),
		.snd_ctrl(snd_ctrl),
		.data_ctrl(data_ctrl)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	task automatic compare_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// Even condition codes test a term and odd ones its inverse.
	function automatic logic cond_holds(input logic [3:0] cond, input psr_flags f);
		logic base;
		case (cond[3:1])
			3'd0: base = f.z;
			3'd1: base = f.c;
			3'd2: base = f.n;
			3'd3: base = f.v;
			3'd4: base = f.c & ~f.z;
			3'd5: base = f.n ~^ f.v;
			3'd6: base = ~f.z & (f.n ~^ f.v);
			default: base = 1'b1;
		endcase
		if (cond == 4'hf)
			return 1'b0; // nv never executes.
		return base ^ cond[0];
	endfunction

	function automatic word rotate_imm(input logic [7:0] imm8, input logic [3:0] rot);
		word value;
		value = {24'd0, imm8};
		repeat (2 * rot)
			value = {value[0], value[31:1]};
		return value;
	endfunction

	function automatic int insn_class(input word i);
		if (i[27:25] == 3'b000 && i[7] && i[4])
			return cls_other; // Multiplies, swap and extra loads and stores.
		if (i[27:23] == 5'b00010 && !i[20] && i[7:4] == 4'b0000)
			return cls_other; // mrs, msr
		if (i[27:23] == 5'b00110 && i[21:20] == 2'b10)
			return cls_other;
		if (i[27:26] == 2'b00)
			return cls_alu;
		if (i[27:25] == 3'b011 && i[4])
			return cls_media;
		if (i[27:25] == 3'b101)
			return cls_branch;
		return cls_other;
	endfunction

	task automatic apply_strobe(input word i, input psr_flags f);
		in_valid = 1'b1;
		insn = i;
		flags = f;
		@(posedge clk);
		#2;
		in_valid = 1'b0;
	endtask

	task automatic verify_decode(input word i, input psr_flags f);
		int         cls;
		logic       cond_undef;
		logic       exp_wb;
		logic       exp_uf;
		logic       exp_undef;
		logic [4:0] exp_kind;
		ptr         exp_offset;
		cls = insn_class(i);
		cond_undef = i[31:28] == 4'hf;
		exp_wb = 1'b0;
		exp_uf = 1'b0;
		exp_undef = cond_undef;
		compare_value("out_valid", 64'(out_valid), 64'(1'b1));
		compare_value("execute", 64'(execute), 64'(cond_holds(i[31:28], f)));
		compare_value("branch", 64'(branch), 64'(cls == cls_branch));
		if (cls == cls_alu) begin
			exp_wb = i[24:23] != 2'b10; // Comparisons have no destination.
			exp_uf = i[24:23] == 2'b10 || i[20];
			exp_undef = cond_undef || (!i[25] && i[4] && i[7]);
			compare_value("data_ctrl.op", 64'(data_ctrl.op), 64'(i[24:21]));
			compare_value("data_ctrl.rn", 64'(data_ctrl.rn), 64'(i[19:16]));
			compare_value("data_ctrl.rd", 64'(data_ctrl.rd), 64'(i[15:12]));
			compare_value("data_ctrl.uses_rn", 64'(data_ctrl.uses_rn),
				64'(!(i[24] && i[23] && i[21])));
			compare_value("data_ctrl.uses_carry_in", 64'(data_ctrl.uses_carry_in),
				64'(i[24:21] inside {4'h5, 4'h6, 4'h7}));
			compare_value("snd_ctrl.is_imm", 64'(snd_ctrl.is_imm), 64'(i[25]));
			if (i[25]) begin
				compare_value("snd_ctrl.imm", 64'(snd_ctrl.imm),
					64'(rotate_imm(i[7:0], i[11:8])));
			end else begin
				case (i[6:5])
					2'b00: exp_kind = 5'b10000;
					2'b01: exp_kind = 5'b01000;
					2'b10: exp_kind = 5'b01010; // asr
					default: exp_kind = (!i[4] && i[11:7] == 5'd0) ? 5'b00001 : 5'b00100;
				endcase
				compare_value("snd_ctrl.r", 64'(snd_ctrl.r), 64'(i[3:0]));
				compare_value("snd_ctrl.shift_by_reg", 64'(snd_ctrl.shift_by_reg), 64'(i[4]));
				compare_value("snd_ctrl.shift_kind", 64'({snd_ctrl.shl, snd_ctrl.shr,
					snd_ctrl.ror, snd_ctrl.sign_extend, snd_ctrl.rrx}), 64'(exp_kind));
				if (i[4])
					compare_value("snd_ctrl.rs", 64'(snd_ctrl.rs), 64'(i[11:8]));
				else
					compare_value("snd_ctrl.shift_imm", 64'(snd_ctrl.shift_imm), 64'(i[11:7]));
			end
		end else if (cls == cls_branch) begin
			exp_wb = i[24];
			exp_offset = 30'($signed(i[23:0]));
			compare_value("branch_offset", 64'(branch_offset), 64'(exp_offset));
			if (i[24])
				compare_value("data_ctrl.rd", 64'(data_ctrl.rd), 64'(4'd14));
		end else begin
			exp_undef = cond_undef || cls == cls_media;
			compare_value("data_ctrl", 64'(data_ctrl), 64'(0));
			compare_value("snd_ctrl", 64'(snd_ctrl), 64'(0));
		end
		compare_value("writeback", 64'(writeback), 64'(exp_wb));
		compare_value("update_flags", 64'(update_flags), 64'(exp_uf));
		compare_value("undefined", 64'(undefined), 64'(exp_undef));
	endtask

	task automatic reset_state();
		compare_value("out_valid", 64'(out_valid), 64'(1'b0));
		compare_value("branch", 64'(branch), 64'(1'b0));
		compare_value("writeback", 64'(writeback), 64'(1'b0));
		compare_value("update_flags", 64'(update_flags), 64'(1'b0));
		compare_value("undefined", 64'(undefined), 64'(1'b0));
		@(posedge clk);
		#2;
		compare_value("out_valid", 64'(out_valid), 64'(1'b0)); // No strobe yet.
	endtask

	task automatic sweep_conditions();
		word i;
		for (int c = 0; c < 16; c++) begin
			for (int fv = 0; fv < 16; fv++) begin
				i = {4'(c), 28'h3a01001}; // mov r1, #1
				apply_strobe(i, psr_flags'(4'(fv)));
				verify_decode(i, psr_flags'(4'(fv)));
			end
		end
	endtask

	task automatic random_alu();
		word      i;
		psr_flags f;
		repeat (200) begin
			i = $urandom;
			i[31:26] = 6'b111000;
			// Comparisons without S would land in the status register moves.
			if (i[24:23] == 2'b10)
				i[20] = 1'b1;
			f = psr_flags'(4'($urandom));
			apply_strobe(i, f);
			verify_decode(i, f);
		end
	endtask

	task automatic random_branches();
		word      i;
		psr_flags f;
		repeat (24) begin
			i = {4'he, 3'b101, 1'($urandom), 24'($urandom)};
			f = psr_flags'(4'($urandom));
			apply_strobe(i, f);
			verify_decode(i, f);
		end
	endtask

	task automatic fixed_classes();
		word encodings [13];
		encodings = '{32'he0000091, 32'he0810392, 32'he1010092, 32'he1d000b0,
			32'he10f0000, 32'he129f000, 32'he329f01f, 32'he5910000, 32'he8900003,
			32'hed900100, 32'hee000010, 32'hef000000, 32'he6000010}; // Last is media.
		foreach (encodings[k]) begin
			apply_strobe(encodings[k], psr_flags'(4'h0));
			verify_decode(encodings[k], psr_flags'(4'h0));
		end
	endtask

	task automatic back_to_back();
		word      seq [4];
		psr_flags fl [4];
		seq = '{32'he3a01001, 32'heb000010, 32'he0912003, 32'he6000010};
		foreach (fl[k])
			fl[k] = psr_flags'(4'($urandom));
		in_valid = 1'b1;
		insn = seq[0];
		flags = fl[0];
		for (int k = 0; k < 4; k++) begin
			@(posedge clk);
			#2;
			if (k < 3) begin
				insn = seq[k + 1];
				flags = fl[k + 1];
			end else begin
				in_valid = 1'b0;
			end
			verify_decode(seq[k], fl[k]);
		end
		@(posedge clk);
		#2;
		compare_value("out_valid", 64'(out_valid), 64'(1'b0));
	endtask

	initial begin
		void'($urandom(32'h2d45));
		errors = 0;
		reset = 1'b1;
		in_valid = 1'b0;
		insn = '0;
		flags = '0;
		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;
		reset_state();
		sweep_conditions();
		random_alu();
		random_branches();
		fixed_classes();
		back_to_back();
		$display("Checks finished with %0d errors", errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial begin
		#(test_cycles * clk_period * 3 / 2);
		$display("Timeout: the tests did not finish in the expected time");
		$display("Result: FAILED");
		$finish;
	end

endmodule

/* src.f */
design/core_pkg.sv
design/core_decode_if.sv
design/core_decode_conds.sv
design/core_decode_snd.sv
design/core_decode_data.sv
design/core_decode.sv
design/core_decode_stage.sv
tests/core_decode_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the decode stage testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module core_decode_tb -f src.f -o sim \
	|| { echo "Build failed"; exit 1; }

output=$(./obj_dir/sim)
echo "$output"
echo "$output" | grep -qx "Result: PASSED" && exit 0 || exit 1
